// File: design/eth_rx_pkg.sv
`default_nettype none

package eth_rx_pkg;

    localparam logic [7:0] HEAD_DATA = 8'h55;
    localparam logic [7:0] WAKE_DATA = 8'h5D;
    localparam int HEAD_LEN = 7;
    localparam int PART_LEN = 4;

    // Width of the shared preamble and check-byte counter in frame_rx.
    localparam int RX_CNT_W = 3;

    localparam int MAX_PAYLOAD = 64;
    localparam int PAY_AW = 6;
    localparam int LEN_W = PAY_AW + 1; // Holds 1 to MAX_PAYLOAD.

    localparam int MAC_ADDR_LEN = 6; // Address field length in bytes.

    localparam logic [31:0] CRC_RESIDUE_INIT = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY = 32'hEDB8_8320; // Reflected form.

    typedef enum logic [3:0] {
        IDLE,
        WAIT,
        HEAD,
        WAKE,
        WORK,
        PART,
        CHECK,
        DONE
    } rx_state_e;

    typedef enum logic [2:0] {
        DEST,
        SRC,
        LEN,
        PAYLOAD,
        TAIL
    } parse_state_e;

    typedef struct packed {
        logic valid;
        logic [7:0] data;
    } mac_byte_t;

    typedef struct packed {
        logic en;
        logic [PAY_AW-1:0] addr;
        logic [7:0] data;
    } pay_wr_t;

    typedef struct packed {
        logic [47:0] dest;
        logic [47:0] src;
        logic [LEN_W-1:0] length;
    } mac_hdr_t;

    typedef struct packed {
        logic [47:0] dest;
        logic [47:0] src;
        logic [LEN_W-1:0] length;
        logic ok;
    } frame_info_t;

endpackage

`default_nettype wire

// File: design/crc32_calc.sv
`timescale 1ns/1ps
`default_nettype none

module crc32_calc (
    input  wire logic        clk,
    input  wire logic        rst,
    input  wire logic        init,
    input  wire logic        en,
    input  wire logic [7:0]  data,
    output logic [31:0]      crc
);
    import eth_rx_pkg::*;

    logic [31:0] residue;

    // Folds one byte through the reflected polynomial with the low bit first.
    function automatic logic [31:0] crc_byte(input logic [31:0] r, input logic [7:0] d);
        logic [31:0] c;
        c = r;
        for (int i = 0; i < 8; i++) begin
            if (c[0] ^ d[i]) c = (c >> 1) ^ CRC_POLY;
            else c = c >> 1;
        end
        return c;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) residue <= CRC_RESIDUE_INIT;
        else if (init) residue <= CRC_RESIDUE_INIT;
        else if (en) residue <= crc_byte(residue, data);
    end

    assign crc = ~residue;

    // The start pulse always precedes the first body byte.
    assert property (@(posedge clk) disable iff (rst)
        !(init && en));

endmodule

`default_nettype wire

// File: design/mac_field_parser.sv
`timescale 1ns/1ps
`default_nettype none

module mac_field_parser (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   start,
    input  wire eth_rx_pkg::mac_byte_t  mac_in,
    output logic                        done,
    output eth_rx_pkg::pay_wr_t         pay_wr,
    output eth_rx_pkg::mac_hdr_t        hdr
);
    import eth_rx_pkg::*;

    parse_state_e state;
    logic [LEN_W-1:0] cnt; // Byte index inside the current field.
    logic [7:0] len_hi;
    logic [15:0] len_raw;

    assign len_raw = {len_hi, mac_in.data};

    assign done = mac_in.valid && (state == PAYLOAD) && (cnt == hdr.length - 1'b1);

    assign pay_wr.en = mac_in.valid && (state == PAYLOAD);
    assign pay_wr.addr = cnt[PAY_AW-1:0];
    assign pay_wr.data = mac_in.data;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= TAIL;
            cnt <= '0;
        end else if (start) begin
            state <= DEST;
            cnt <= '0;
        end else if (mac_in.valid) begin
            case (state)
                DEST, SRC: begin
                    if (cnt == LEN_W'(MAC_ADDR_LEN - 1)) begin
                        state <= (state == DEST) ? SRC : LEN;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                LEN: begin
                    if (cnt == LEN_W'(1)) begin
                        state <= PAYLOAD;
                        cnt <= '0;
                    end else begin
                        cnt <= cnt + 1'b1;
                    end
                end
                PAYLOAD: begin
                    if (done) state <= TAIL; // Check byte 0 then passes unparsed.
                    else cnt <= cnt + 1'b1;
                end
                default: state <= TAIL;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (mac_in.valid) begin
            if (state == DEST) hdr.dest <= {hdr.dest[39:0], mac_in.data};
            if (state == SRC) hdr.src <= {hdr.src[39:0], mac_in.data};
            if (state == LEN && cnt == '0) len_hi <= mac_in.data;
            if (state == LEN && cnt == LEN_W'(1)) begin
                // Oversized lengths are clipped to the store depth.
                if (len_raw > 16'(MAX_PAYLOAD)) hdr.length <= LEN_W'(MAX_PAYLOAD);
                else if (len_raw == '0) hdr.length <= LEN_W'(1);
                else hdr.length <= len_raw[LEN_W-1:0];
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        pay_wr.en |-> cnt < LEN_W'(MAX_PAYLOAD));

endmodule

`default_nettype wire

// File: design/frame_store.sv
`timescale 1ns/1ps
`default_nettype none

module frame_store (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire eth_rx_pkg::pay_wr_t      pay_wr,
    input  wire eth_rx_pkg::mac_hdr_t     hdr,
    input  wire logic                     fs_read,
    input  wire logic                     frame_ok,
    output logic                          fd_read,
    output logic                          frame_valid,
    output eth_rx_pkg::frame_info_t       frame_info,
    input  wire logic [eth_rx_pkg::PAY_AW-1:0] rd_addr,
    output logic [7:0]                    rd_data
);
    import eth_rx_pkg::*;

    logic [7:0] mem [MAX_PAYLOAD];
    logic busy;
    logic read_pulse;
    logic take;

    assign take = fs_read && !busy;

    always_ff @(posedge clk) begin
        if (pay_wr.en) mem[pay_wr.addr] <= pay_wr.data;
        rd_data <= mem[rd_addr];
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            read_pulse <= 1'b0;
        end else begin
            read_pulse <= take;
            busy <= fs_read; // Held until the request drops.
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            frame_info.dest <= hdr.dest;
            frame_info.src <= hdr.src;
            frame_info.length <= hdr.length;
            frame_info.ok <= frame_ok;
        end
    end

    // The descriptor and the handshake back to the sequencer share one pulse.
    assign frame_valid = read_pulse;
    assign fd_read = read_pulse;

endmodule

`default_nettype wire

// File: design/frame_rx.sv
`timescale 1ns/1ps
`default_nettype none

module frame_rx (
    input  wire logic                  clk,
    input  wire logic                  rst,
    input  wire logic                  rxdv,
    input  wire logic [7:0]            rxd,
    output logic                       fs_mac,
    input  wire logic                  fd_mac,
    output logic                       fs_read,
    input  wire logic                  fd_read,
    input  wire logic [31:0]           crc,
    output logic                       crc_en,
    output logic                       frame_ok,
    output eth_rx_pkg::mac_byte_t      mac_out
);
    import eth_rx_pkg::*;

    rx_state_e state, next_state;
    logic [RX_CNT_W-1:0] cnt;
    logic [31:0] checksum;
    logic is_head;
    logic take_check;

    assign is_head = rxdv && (rxd == HEAD_DATA);
    assign take_check = rxdv && ((state == WORK && fd_mac) || state == PART);

    assign fs_read = (state == DONE);

    always_comb begin
        next_state = state;
        case (state)
            IDLE: next_state = WAIT;
            WAIT: begin
                if (is_head) next_state = HEAD;
            end
            HEAD: begin
                if (is_head && cnt >= RX_CNT_W'(HEAD_LEN - 1)) next_state = WAKE;
                else if (!is_head) next_state = WAIT;
            end
            WAKE: begin
                // Extra preamble bytes keep the sequencer waiting for the start byte.
                if (rxdv && rxd == WAKE_DATA) next_state = WORK;
                else if (!is_head) next_state = IDLE;
            end
            WORK: begin
                if (!rxdv) next_state = IDLE;
                else if (fd_mac) next_state = PART;
            end
            PART: begin
                if (!rxdv) next_state = IDLE;
                else if (cnt >= RX_CNT_W'(PART_LEN - 1)) next_state = CHECK;
            end
            CHECK: next_state = DONE;
            DONE: begin
                if (fd_read) next_state = WAIT;
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt <= '0;
        end else begin
            state <= next_state;
            if (state == WAIT && is_head) cnt <= RX_CNT_W'(1);
            else if (state == HEAD && is_head) cnt <= cnt + 1'b1;
            else if (state == WORK && rxdv && fd_mac) cnt <= RX_CNT_W'(1); // Byte 0 taken.
            else if (state == PART && rxdv) cnt <= cnt + 1'b1;
        end
    end

    // Check bytes arrive least significant first.
    always_ff @(posedge clk) begin
        if (take_check) checksum <= {rxd, checksum[31:8]};
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            fs_mac <= 1'b0;
            crc_en <= 1'b0;
            mac_out <= '0;
        end else begin
            fs_mac <= (state == WAKE) && (next_state == WORK);
            mac_out.valid <= (state == WORK) && rxdv;
            mac_out.data <= rxd;
            crc_en <= (state == WORK) && rxdv && !fd_mac; // Check byte 0 stays out of the CRC.
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) frame_ok <= 1'b0;
        else if (state == IDLE || state == WAIT) frame_ok <= 1'b0;
        else if (state == CHECK && checksum == crc) frame_ok <= 1'b1;
    end

    // A read request only follows a completed check.
    assert property (@(posedge clk) disable iff (rst)
        $rose(fs_read) |-> $past(state) == CHECK);

    assert property (@(posedge clk) disable iff (rst)
        fd_read |-> fs_read);

    assert property (@(posedge clk) disable iff (rst)
        state == DONE |=> $stable(frame_ok));

endmodule

`default_nettype wire

// File: design/eth_rx_top.sv
`timescale 1ns/1ps
`default_nettype none

module eth_rx_top (
    input  wire logic                     clk,
    input  wire logic                     rst,
    input  wire logic                     rxdv,
    input  wire logic [7:0]               rxd,
    output logic                          frame_valid,
    output eth_rx_pkg::frame_info_t       frame_info,
    input  wire logic [eth_rx_pkg::PAY_AW-1:0] rd_addr,
    output logic [7:0]                    rd_data
);
    import eth_rx_pkg::*;

    mac_byte_t mac_out;
    pay_wr_t pay_wr;
    mac_hdr_t hdr;
    logic fs_mac;
    logic fd_mac;
    logic fs_read;
    logic fd_read;
    logic crc_en;
    logic frame_ok;
    logic [31:0] crc;

    frame_rx i_frame_rx (
        .clk      (clk),
        .rst      (rst),
        .rxdv     (rxdv),
        .rxd      (rxd),
        .fs_mac   (fs_mac),
        .fd_mac   (fd_mac),
        .fs_read  (fs_read),
        .fd_read  (fd_read),
        .crc      (crc),
        .crc_en   (crc_en),
        .frame_ok (frame_ok),
        .mac_out  (mac_out)
    );

    crc32_calc i_crc32_calc (
        .clk  (clk),
        .rst  (rst),
        .init (fs_mac),
        .en   (crc_en),
        .data (mac_out.data),
        .crc  (crc)
    );

    mac_field_parser i_mac_field_parser (
        .clk    (clk),
        .rst    (rst),
        .start  (fs_mac),
        .mac_in (mac_out),
        .done   (fd_mac),
        .pay_wr (pay_wr),
        .hdr    (hdr)
    );

    frame_store i_frame_store (
        .clk         (clk),
        .rst         (rst),
        .pay_wr      (pay_wr),
        .hdr         (hdr),
        .fs_read     (fs_read),
        .frame_ok    (frame_ok),
        .fd_read     (fd_read),
        .frame_valid (frame_valid),
        .frame_info  (frame_info),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

endmodule

`default_nettype wire

// File: tests/tb_eth_rx.sv
`timescale 1ns/1ps
`default_nettype none

module tb_eth_rx;
    import eth_rx_pkg::*;

    localparam int FRAME_BYTES_MAX = HEAD_LEN + 1 + 2 * MAC_ADDR_LEN + 2 + MAX_PAYLOAD + PART_LEN;
    localparam int GAP_CYCLES = 4;
    localparam int TIMEOUT_CYCLES = 20 * (FRAME_BYTES_MAX + GAP_CYCLES);
    localparam int VALID_DELAY = 3; // Edges from the last check byte to frame_valid.

    logic clk;
    logic rst;
    logic rxdv;
    logic [7:0] rxd;
    logic frame_valid;
    frame_info_t frame_info;
    logic [PAY_AW-1:0] rd_addr;
    logic [7:0] rd_data;

    int cycle = 0;
    int mismatch_count = 0;
    int event_count = 0;
    int seed_value;
    frame_info_t got_info[$];
    int got_cycle[$];
    int check_cycle[$]; // Cycle of the last check byte of each complete frame.
    logic [7:0] body_q[$];
    logic [7:0] frame_q[$];
    logic [7:0] payload [MAX_PAYLOAD];
    logic [47:0] last_dest;
    logic [47:0] last_src;
    int last_len;

    eth_rx_top i_dut (
        .clk         (clk),
        .rst         (rst),
        .rxdv        (rxdv),
        .rxd         (rxd),
        .frame_valid (frame_valid),
        .frame_info  (frame_info),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data)
    );

    initial clk = 1'b0;
    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES) begin
            $display("Timeout after %0d cycles, the tests did not run to the end.", cycle);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Outputs change on the rising edge, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (!rst && frame_valid) begin
            got_info.push_back(frame_info);
            got_cycle.push_back(cycle);
        end
    end

    task automatic check_info(input string name, input frame_info_t exp, input frame_info_t act);
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s expected %h, got %h", $time, name, exp, act);
        end
    endtask

    // Reflected CRC-32 over body_q that takes the low bit of each byte first.
    task automatic compute_crc(output logic [31:0] fcs);
        logic [31:0] r;
        logic fb;
        r = 32'hFFFF_FFFF;
        foreach (body_q[i]) begin
            for (int b = 0; b < 8; b++) begin
                fb = r[0] ^ body_q[i][b];
                r = r >> 1;
                if (fb) r = r ^ 32'hEDB8_8320;
            end
        end
        fcs = ~r;
    endtask

    function automatic frame_info_t make_info(input logic [47:0] dest, input logic [47:0] src,
                                              input int len, input logic ok);
        frame_info_t info;
        info.dest = dest;
        info.src = src;
        info.length = LEN_W'(len);
        info.ok = ok;
        return info;
    endfunction

    task automatic send_frame(input logic [47:0] dest, input logic [47:0] src, input int len,
                              input bit new_payload, input int head_cnt,
                              input logic [7:0] wake, input int stray_at,
                              input int flip_at, input int abort_at);
        logic [31:0] fcs;
        logic [7:0] b;
        int n;
        body_q.delete();
        frame_q.delete();
        for (int i = 5; i >= 0; i--) body_q.push_back(dest[8*i +: 8]);
        for (int i = 5; i >= 0; i--) body_q.push_back(src[8*i +: 8]);
        body_q.push_back(8'(len >> 8));
        body_q.push_back(8'(len));
        for (int i = 0; i < len; i++) begin
            if (new_payload) payload[i] = 8'($urandom);
            body_q.push_back(payload[i]);
        end
        compute_crc(fcs);
        for (int i = 0; i < head_cnt; i++) frame_q.push_back((i == stray_at) ? 8'hA5 : 8'h55);
        frame_q.push_back(wake);
        foreach (body_q[i]) frame_q.push_back(body_q[i]);
        for (int i = 0; i < PART_LEN; i++) begin
            b = fcs[8*i +: 8];
            if (i == flip_at) b = ~b;
            frame_q.push_back(b);
        end
        n = (abort_at >= 0) ? abort_at : frame_q.size();
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            rxdv = 1'b1;
            rxd = frame_q[i];
        end
        if (abort_at < 0) check_cycle.push_back(cycle);
        repeat (GAP_CYCLES) begin
            @(negedge clk);
            rxdv = 1'b0;
            rxd = 8'h00;
        end
    endtask

    task automatic expect_frame(input string name, input frame_info_t exp);
        int due;
        int seen;
        due = check_cycle.pop_front();
        if (got_info.size() == 0) begin
            event_count++;
            $display("No frame_valid was seen for the %s frame.", name);
        end else begin
            check_info({name, " frame_info"}, exp, got_info.pop_front());
            seen = got_cycle.pop_front();
            if (seen != due + VALID_DELAY) begin
                event_count++;
                $display("The %s frame gave frame_valid %0d cycles after its last check byte.",
                         name, seen - due);
            end
        end
    endtask

    task automatic no_frame_seen(input string name);
        check_cycle.delete();
        if (got_info.size() != 0) begin
            event_count += got_info.size();
            $display("Unexpected frame_valid after the %s frame.", name);
            got_info.delete();
            got_cycle.delete();
        end
    endtask

    task automatic send_good(input string name, input int len);
        last_dest = {16'($urandom), $urandom};
        last_src = {16'($urandom), $urandom};
        last_len = len;
        send_frame(last_dest, last_src, len, 1'b1, HEAD_LEN, WAKE_DATA, -1, -1, -1);
        expect_frame(name, make_info(last_dest, last_src, len, 1'b1));
        no_frame_seen(name);
    endtask

    task automatic good_frame();
        send_good("good", 1 + ($urandom % MAX_PAYLOAD));
    endtask

    task automatic payload_readback();
        for (int a = 0; a < last_len; a++) begin
            @(negedge clk);
            rd_addr = PAY_AW'(a);
            @(negedge clk);
            check_byte($sformatf("rd_data[%0d]", a), payload[a], rd_data);
        end
    endtask

    task automatic corrupted_check();
        send_frame(last_dest, last_src, last_len, 1'b0, HEAD_LEN, WAKE_DATA, -1, 2, -1);
        expect_frame("corrupted", make_info(last_dest, last_src, last_len, 1'b0));
        no_frame_seen("corrupted");
    endtask

    task automatic preamble_rules();
        send_frame(48'h0A0B0C0D0E0F, 48'h102030405060, 12, 1'b1, HEAD_LEN - 1, WAKE_DATA,
                   -1, -1, -1);
        no_frame_seen("short preamble");
        send_good("after short preamble", 1 + ($urandom % MAX_PAYLOAD));
        send_frame(48'h0A0B0C0D0E0F, 48'h102030405060, 12, 1'b1, HEAD_LEN, 8'hD5, -1, -1, -1);
        no_frame_seen("wrong start byte");
        send_good("after wrong start byte", 1 + ($urandom % MAX_PAYLOAD));
        send_frame(48'h0A0B0C0D0E0F, 48'h102030405060, 12, 1'b1, HEAD_LEN, WAKE_DATA,
                   3, -1, -1);
        no_frame_seen("stray preamble byte");
        send_good("after stray preamble byte", 1 + ($urandom % MAX_PAYLOAD));
    endtask

    task automatic abort_mid_payload();
        int len;
        len = 8 + ($urandom % 40);
        send_frame({16'($urandom), $urandom}, {16'($urandom), $urandom}, len, 1'b1, HEAD_LEN,
                   WAKE_DATA, -1, -1, HEAD_LEN + 1 + 2 * MAC_ADDR_LEN + 2 + len / 2);
        no_frame_seen("aborted");
        send_good("after abort", 1 + ($urandom % MAX_PAYLOAD));
    endtask

    task automatic back_to_back();
        frame_info_t exp [3];
        int lens [3];
        logic [47:0] d;
        logic [47:0] s;
        lens[0] = 1;
        lens[1] = MAX_PAYLOAD;
        lens[2] = 1 + ($urandom % MAX_PAYLOAD);
        for (int i = 0; i < 3; i++) begin
            d = {16'($urandom), $urandom};
            s = {16'($urandom), $urandom};
            exp[i] = make_info(d, s, lens[i], 1'b1);
            send_frame(d, s, lens[i], 1'b1, HEAD_LEN, WAKE_DATA, -1, -1, -1);
        end
        for (int i = 0; i < 3; i++) expect_frame($sformatf("back-to-back %0d", i), exp[i]);
        no_frame_seen("back-to-back");
    endtask

    initial begin
        seed_value = $urandom(78664);
        rst = 1'b1;
        rxdv = 1'b0;
        rxd = 8'h00;
        rd_addr = '0;
        repeat (16) @(negedge clk);
        rst = 1'b0;
        good_frame();
        payload_readback();
        corrupted_check();
        preamble_rules();
        abort_mid_payload();
        back_to_back();
        $display("Errors: %0d mismatches, %0d frame_valid errors", mismatch_count, event_count);
        if (mismatch_count == 0 && event_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
design/eth_rx_pkg.sv
design/crc32_calc.sv
design/mac_field_parser.sv
design/frame_store.sv
design/frame_rx.sv
design/eth_rx_top.sv
tests/tb_eth_rx.sv

// File: Bender.yml
package:
  name: eth_rx

sources:
  - design/eth_rx_pkg.sv
  - design/crc32_calc.sv
  - design/mac_field_parser.sv
  - design/frame_store.sv
  - design/frame_rx.sv
  - design/eth_rx_top.sv
  - target: test
    files:
      - tests/tb_eth_rx.sv
